/* src.f */
+incdir+dv
common/crc_pkg.sv
host_interface/host_interface.sv
source/crc_data_buffer.sv
source/crc_engine.sv
source/crc_ahb_top.sv
dv/crc_ahb_tb.sv

/* run.sh */
#!/bin/sh
# Builds the CRC testbench with Verilator and runs it
# A failing test ends in $fatal, which gives a nonzero exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module crc_ahb_tb \
	-Mdir obj_dir \
	-f src.f

./obj_dir/Vcrc_ahb_tb

/* dv/crc_ahb_tasks.svh */
//////////////////////////////
// Bus tasks, CRC reference model and checks
// Included inside the testbench module and uses its signals
// One transfer at a time, the bus goes IDLE between transfers
//////////////////////////////
`ifndef CRC_AHB_TASKS_SVH
`define CRC_AHB_TASKS_SVH

// Reference model state
logic [31:0] model_crc;
logic [31:0] model_init;
logic [31:0] model_poly;
int          model_width;
logic [1:0]  model_rev_in;
logic        model_rev_out;
// Wait states seen on the bus so far
int          stall_cycles = 0;

//////////////////////////////
// AHB-Lite transfers
//////////////////////////////

// Address phase of one NONSEQ transfer, then IDLE behind it
task automatic start_transfer(input crc_pkg::reg_addr_t idx, input logic is_write,
                              input logic [2:0] size);
	HSElx  <= 1'b1;
	HADDR  <= {27'h0, idx, 2'b00};
	HTRANS <= HTRANS_NONSEQ;
	HWRITE <= is_write;
	HSIZE  <= size;
	@(posedge HCLK);
	HSElx  <= 1'b0;
	HTRANS <= HTRANS_IDLE;
endtask

// Data phase ends on the first edge after HREADYOUT is seen high mid-cycle
task automatic complete_data_phase(output logic [31:0] rdata);
	@(negedge HCLK);
	while (!HREADYOUT)
	begin
		stall_cycles++;
		@(negedge HCLK);
	end
	rdata = HRDATA;
	// Every transfer ends with an OKAY response
	check_value("HRESP", {31'h0, HRESP}, 32'h0);
	@(posedge HCLK);
endtask

task automatic ahb_write(input crc_pkg::reg_addr_t idx, input logic [31:0] data,
                         input logic [2:0] size);
	logic [31:0] unused_rdata;
	start_transfer(idx, 1'b1, size);
	// Narrow data rides on the low lanes
	HWDATA <= data;
	complete_data_phase(unused_rdata);
endtask

task automatic ahb_read(input crc_pkg::reg_addr_t idx, output logic [31:0] data);
	start_transfer(idx, 1'b0, SIZE_WORD);
	complete_data_phase(data);
endtask

//////////////////////////////
// Reference CRC model
//////////////////////////////

function automatic int width_of(input logic [1:0] field);
	case (field)
		2'd1: return 16;
		2'd2: return 8;
		2'd3: return 7;
		default: return 32;
	endcase
endfunction

function automatic logic [31:0] width_ones(input int width);
	return (width >= 32) ? 32'hFFFF_FFFF : ((32'd1 << width) - 32'd1);
endfunction

// Mirror every chunk of the word, chunk 1 leaves it unchanged
function automatic logic [31:0] mirror_chunks(input logic [31:0] w, input int chunk);
	logic [31:0] r;
	for (int i = 0; i < 32; i++)
		r[(i / chunk) * chunk + chunk - 1 - (i % chunk)] = w[i];
	return r;
endfunction

function automatic logic [31:0] cr_value(input logic [1:0] size, input logic [1:0] rev_in,
                                         input logic rev_out);
	// Bit 0 asks for a chain reset
	return {24'h0, rev_out, rev_in, size, 3'b001};
endfunction

task automatic model_reset();
	model_crc = model_init & width_ones(model_width);
endtask

// Folds one DR write, low byte first and each byte MSB first
task automatic crc_model(input logic [31:0] data, input logic [2:0] size);
	int          nbytes;
	int          chunk;
	logic [31:0] word;
	logic [7:0]  cur;
	logic        top;
	nbytes = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
	case (model_rev_in)
		2'd1: chunk = 8;
		2'd2: chunk = 16;
		2'd3: chunk = 32;
		default: chunk = 1;
	endcase
	// Reversal never spans more than the transfer
	if (chunk > 8 * nbytes)
		chunk = 8 * nbytes;
	word = mirror_chunks(data, chunk);
	for (int b = 0; b < nbytes; b++)
	begin
		cur = word[8 * b +: 8];
		for (int k = 7; k >= 0; k--)
		begin
			top       = model_crc[model_width - 1] ^ cur[k];
			model_crc = (model_crc << 1) & width_ones(model_width);
			if (top)
				model_crc = model_crc ^ (model_poly & width_ones(model_width));
		end
	end
endtask

// DR as the bus should show it
function automatic logic [31:0] expected_dr();
	logic [31:0] c;
	logic [31:0] r;
	c = model_crc & width_ones(model_width);
	r = 32'h0;
	for (int i = 0; i < model_width; i++)
		r[model_width - 1 - i] = c[i];
	return model_rev_out ? r : c;
endfunction

//////////////////////////////
// Checks and setup helpers
//////////////////////////////

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
	assert (got === exp)
	else
		fail_run($sformatf("ERROR %s got %08h expected %08h", name, got, exp));
endtask

task automatic read_check(input crc_pkg::reg_addr_t idx, input string name,
                          input logic [31:0] exp);
	logic [31:0] got;
	ahb_read(idx, got);
	check_value(name, got, exp);
endtask

task automatic check_dr(input string name);
	read_check(crc_pkg::CRC_DR_ADDR, name, expected_dr());
endtask

// POL, INIT, then CR with a chain reset
task automatic configure(input logic [31:0] poly, input logic [31:0] init,
                         input logic [1:0] size, input logic [1:0] rev_in,
                         input logic rev_out);
	ahb_write(crc_pkg::CRC_POL_ADDR, poly, SIZE_WORD);
	ahb_write(crc_pkg::CRC_INIT_ADDR, init, SIZE_WORD);
	ahb_write(crc_pkg::CRC_CR_ADDR, cr_value(size, rev_in, rev_out), SIZE_WORD);
	model_poly    = poly;
	model_init    = init;
	model_width   = width_of(size);
	model_rev_in  = rev_in;
	model_rev_out = rev_out;
	model_reset();
endtask

task automatic write_data(input logic [31:0] data, input logic [2:0] size);
	ahb_write(crc_pkg::CRC_DR_ADDR, data, size);
	crc_model(data, size);
endtask

// Published check value of "123456789", model and DUT both must hit it
task automatic check_known_vector(input logic [31:0] poly, input logic [31:0] init,
                                  input logic [1:0] size, input logic [31:0] check,
                                  input string name);
	logic [7:0] ch;
	configure(poly, init, size, 2'd0, 1'b0);
	ch = 8'h31;
	for (int i = 0; i < 9; i++)
	begin
		write_data({24'h0, ch}, SIZE_BYTE);
		ch = ch + 8'd1;
	end
	check_value({name, " model"}, expected_dr(), check);
	check_dr(name);
endtask

`endif

/* dv/crc_ahb_tb.sv */
//////////////////////////////
// Directed testbench of the AHB-Lite CRC unit
// HREADY is held high, the slave alone adds wait states
// The first failing check ends the run
//////////////////////////////
`timescale 1ns/1ps

module crc_ahb_tb;

	localparam int CLK_HALF     = 2;
	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_SEED  = 91260;
	// Watchdog budget, transfers over all tests with room to spare
	localparam int TRANSFER_BUDGET     = 200;
	localparam int MAX_TRANSFER_CYCLES = 12;
	localparam int TIMEOUT_MARGIN      = 4;

	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [2:0] SIZE_BYTE     = 3'd0;
	localparam logic [2:0] SIZE_HALF     = 3'd1;
	localparam logic [2:0] SIZE_WORD     = 3'd2;

	logic        HCLK = 1'b0;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic [2:0]  HSIZE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	crc_ahb_top crc_ahb_top_i
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSIZE     (HSIZE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	always #CLK_HALF HCLK = ~HCLK;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	`include "crc_ahb_tasks.svh"

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic reset_value_test();
		read_check(crc_pkg::CRC_INIT_ADDR, "CRC_INIT", 32'hFFFF_FFFF);
		read_check(crc_pkg::CRC_POL_ADDR, "CRC_POL", 32'h04C1_1DB7);
		read_check(crc_pkg::CRC_CR_ADDR, "CRC_CR", 32'h0);
		read_check(crc_pkg::CRC_IDR_ADDR, "CRC_IDR", 32'h0);
		read_check(crc_pkg::CRC_DR_ADDR, "CRC_DR", 32'hFFFF_FFFF);
	endtask

	task automatic register_access_test();
		logic [31:0] value;
		value = $urandom();
		ahb_write(crc_pkg::CRC_INIT_ADDR, value, SIZE_WORD);
		read_check(crc_pkg::CRC_INIT_ADDR, "CRC_INIT", value);
		value = $urandom();
		ahb_write(crc_pkg::CRC_POL_ADDR, value, SIZE_WORD);
		read_check(crc_pkg::CRC_POL_ADDR, "CRC_POL", value);
		value = $urandom();
		ahb_write(crc_pkg::CRC_IDR_ADDR, value, SIZE_WORD);
		read_check(crc_pkg::CRC_IDR_ADDR, "CRC_IDR", value & 32'hFF);
		// Bit 0 is a reset request and reads back zero
		value = $urandom() | 32'h1;
		ahb_write(crc_pkg::CRC_CR_ADDR, value, SIZE_WORD);
		read_check(crc_pkg::CRC_CR_ADDR, "CRC_CR", value & 32'hF8);
	endtask

	task automatic crc32_default_test();
		check_known_vector(32'h04C1_1DB7, 32'hFFFF_FFFF, 2'd0, 32'h0376_E6E7, "CRC_DR crc32");
		configure(32'h04C1_1DB7, 32'hFFFF_FFFF, 2'd0, 2'd0, 1'b0);
		repeat (8)
			write_data($urandom(), SIZE_WORD);
		check_dr("CRC_DR crc32 stream");
	endtask

	task automatic width_size_test();
		logic [31:0] polys [1:3] = '{32'h0000_8005, 32'h0000_0007, 32'h0000_0009};
		logic [31:0] checks [1:3] = '{32'h0000_FEE8, 32'h0000_00F4, 32'h0000_0075};
		for (int f = 1; f < 4; f++)
		begin
			check_known_vector(polys[f], 32'h0, 2'(f), checks[f],
			                   $sformatf("CRC_DR width %0d", width_of(2'(f))));
			configure(polys[f], $urandom(), 2'(f), 2'd0, 1'b0);
			for (int n = 0; n < 6; n++)
				write_data($urandom(), (n % 2 == 0) ? SIZE_BYTE : SIZE_HALF);
			write_data($urandom(), SIZE_WORD);
			check_dr($sformatf("CRC_DR narrow writes width %0d", width_of(2'(f))));
		end
	endtask

	task automatic reversal_test();
		logic [1:0] size;
		for (int r = 0; r < 4; r++)
			for (int o = 0; o < 2; o++)
			begin
				// Width moves with the reversal so rev_out spans every width
				size = 2'(r + o);
				configure(32'h04C1_1DB7, $urandom(), size, 2'(r), 1'(o));
				write_data($urandom(), SIZE_WORD);
				write_data($urandom(), SIZE_HALF);
				write_data($urandom(), SIZE_BYTE);
				check_dr($sformatf("CRC_DR rev_in %0d rev_out %0d", r, o));
			end
	endtask

	task automatic backpressure_test();
		int          stalls_before;
		logic [31:0] new_init;
		configure(32'h04C1_1DB7, 32'hFFFF_FFFF, 2'd0, 2'd0, 1'b0);
		stalls_before = stall_cycles;
		repeat (3)
			write_data($urandom(), SIZE_WORD);
		assert (stall_cycles > stalls_before)
		else
			fail_run("Back-to-back DR writes were accepted without any wait state");
		check_dr("CRC_DR after back-to-back writes");

		// Chain reset lands while bytes are still queued
		ahb_write(crc_pkg::CRC_DR_ADDR, $urandom(), SIZE_WORD);
		ahb_write(crc_pkg::CRC_DR_ADDR, $urandom(), SIZE_WORD);
		ahb_write(crc_pkg::CRC_CR_ADDR, cr_value(2'd0, 2'd0, 1'b0), SIZE_WORD);
		model_reset();
		// New INIT must not reach the pending reset
		stalls_before = stall_cycles;
		new_init = $urandom();
		ahb_write(crc_pkg::CRC_INIT_ADDR, new_init, SIZE_WORD);
		assert (stall_cycles > stalls_before)
		else
			fail_run("INIT write did not wait for the pending chain reset");
		model_init = new_init;
		write_data($urandom(), SIZE_WORD);
		check_dr("CRC_DR after pending chain reset");
	endtask

	//////////////////////////////
	// Run control
	//////////////////////////////

	initial
	begin
		HRESETn <= 1'b0;
		HSElx   <= 1'b0;
		HADDR   <= 32'h0;
		HTRANS  <= HTRANS_IDLE;
		HWRITE  <= 1'b0;
		HSIZE   <= SIZE_WORD;
		HWDATA  <= 32'h0;
		HREADY  <= 1'b1;
		void'($urandom(RANDOM_SEED));
		repeat (RESET_CYCLES)
			@(posedge HCLK);
		HRESETn <= 1'b1;
		reset_value_test();
		register_access_test();
		crc32_default_test();
		width_size_test();
		reversal_test();
		backpressure_test();
		$display("*** PASSED ***");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(2 * CLK_HALF * (RESET_CYCLES + TRANSFER_BUDGET * MAX_TRANSFER_CYCLES) * TIMEOUT_MARGIN);
		fail_run("Watchdog expired before the tests finished");
	end

endmodule

/* source/crc_ahb_top.sv */
//////////////////////////////
// CRC unit as an AHB-Lite slave
// Bus front end, one-word buffer and byte-serial engine
//////////////////////////////
`timescale 1ns/1ps

module crc_ahb_top
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic                HSElx,
	input  logic [31:0]         HADDR,
	input  logic [1:0]          HTRANS,
	input  logic                HWRITE,
	input  logic [2:0]          HSIZE,
	input  crc_pkg::crc_word_t  HWDATA,
	input  logic                HREADY,
	output crc_pkg::crc_word_t  HRDATA,
	output logic                HREADYOUT,
	output logic                HRESP
);

	// Host to buffer and engine
	crc_pkg::crc_word_t  bus_wr;
	crc_pkg::bus_size_t  bus_size;
	logic                buffer_write_en;
	logic                crc_init_en;
	logic                crc_idr_en;
	logic                crc_poly_en;
	logic                reset_chain;
	crc_pkg::poly_size_t crc_poly_size;
	crc_pkg::rev_in_t    rev_in_type;
	logic                rev_out_type;

	// Engine and buffer back to host
	crc_pkg::crc_word_t  crc_out;
	crc_pkg::crc_word_t  crc_init_out;
	crc_pkg::crc_word_t  crc_poly_out;
	crc_pkg::crc_byte_t  crc_idr_out;
	logic                buffer_full;
	logic                reset_pending;
	logic                read_wait;

	// Buffer to engine byte stream
	logic                byte_valid;
	logic                byte_ready;
	crc_pkg::crc_byte_t  byte_data;
	logic                engine_busy;

	host_interface host_interface_i
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSElx           (HSElx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HWRITE          (HWRITE),
		.HSIZE           (HSIZE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.buffer_write_en (buffer_write_en),
		.crc_init_en     (crc_init_en),
		.crc_idr_en      (crc_idr_en),
		.crc_poly_en     (crc_poly_en),
		.reset_chain     (reset_chain),
		.crc_poly_size   (crc_poly_size),
		.rev_in_type     (rev_in_type),
		.rev_out_type    (rev_out_type),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait)
	);

	crc_data_buffer crc_data_buffer_i
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.buffer_write_en (buffer_write_en),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.rev_in_type     (rev_in_type),
		.engine_busy     (engine_busy),
		.byte_ready      (byte_ready),
		.buffer_full     (buffer_full),
		.read_wait       (read_wait),
		.byte_valid      (byte_valid),
		.byte_data       (byte_data)
	);

	crc_engine crc_engine_i
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.bus_wr          (bus_wr),
		.crc_init_en     (crc_init_en),
		.crc_poly_en     (crc_poly_en),
		.crc_idr_en      (crc_idr_en),
		.reset_chain     (reset_chain),
		.crc_poly_size   (crc_poly_size),
		.rev_out_type    (rev_out_type),
		.byte_valid      (byte_valid),
		.byte_data       (byte_data),
		.byte_ready      (byte_ready),
		.engine_busy     (engine_busy),
		.reset_pending   (reset_pending),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out)
	);

endmodule

/* source/crc_engine.sv */
//////////////////////////////
// Byte-serial CRC datapath, MSB first
// The 7-bit CRC folds each byte bit by bit from the top
// A chain reset waits until the buffer is empty
//////////////////////////////
`timescale 1ns/1ps

module crc_engine
(
	input  logic                 HCLK,
	input  logic                 HRESETn,
	input  crc_pkg::crc_word_t   bus_wr,
	input  logic                 crc_init_en,
	input  logic                 crc_poly_en,
	input  logic                 crc_idr_en,
	input  logic                 reset_chain,
	input  crc_pkg::poly_size_t  crc_poly_size,
	input  logic                 rev_out_type,
	input  logic                 byte_valid,
	input  crc_pkg::crc_byte_t   byte_data,
	output logic                 byte_ready,
	output logic                 engine_busy,
	output logic                 reset_pending,
	output crc_pkg::crc_word_t   crc_out,
	output crc_pkg::crc_word_t   crc_init_out,
	output crc_pkg::crc_word_t   crc_poly_out,
	output crc_pkg::crc_byte_t   crc_idr_out
);

	crc_pkg::crc_state_e state_ff;
	crc_pkg::crc_byte_t  byte_ff;
	crc_pkg::crc_word_t  crc_ff;
	crc_pkg::crc_word_t  init_ff;
	crc_pkg::crc_word_t  poly_ff;
	crc_pkg::crc_byte_t  idr_ff;
	logic                pending_ff;
	logic                take;
	logic                reset_req;
	logic                reset_now;
	crc_pkg::crc_word_t  crc_masked;
	crc_pkg::crc_word_t  crc_mirror;
	logic [4:0]          rev_shift;

	// Valid bits of the selected width
	function automatic crc_pkg::crc_word_t width_mask(input crc_pkg::poly_size_t size);
		case (size)
			crc_pkg::POLY_16: return 32'h0000_FFFF;
			crc_pkg::POLY_8:  return 32'h0000_00FF;
			crc_pkg::POLY_7:  return 32'h0000_007F;
			default:          return 32'hFFFF_FFFF;
		endcase
	endfunction

	// One byte into the CRC, feedback taken from the top bit of the width
	function automatic crc_pkg::crc_word_t fold_byte(input crc_pkg::crc_word_t crc,
	                                                 input crc_pkg::crc_byte_t data,
	                                                 input crc_pkg::crc_word_t poly,
	                                                 input crc_pkg::poly_size_t size);
		crc_pkg::crc_word_t c;
		logic               fb;
		c = crc;
		for (int i = 7; i >= 0; i--)
		begin
			case (size)
				crc_pkg::POLY_16: fb = c[15];
				crc_pkg::POLY_8:  fb = c[7];
				crc_pkg::POLY_7:  fb = c[6];
				default:          fb = c[31];
			endcase
			fb = fb ^ data[i];
			c  = c << 1;
			if (fb)
				c = c ^ poly;
		end
		return c & width_mask(size);
	endfunction

	//////////////////////////////
	// Byte handshake and chain reset
	//////////////////////////////

	// No byte moves in the cycle a reset is requested
	assign byte_ready = !reset_chain;
	assign take       = byte_valid && byte_ready;

	// Bytes still queued in the buffer belong to the old chain
	assign reset_req     = reset_chain || pending_ff;
	assign reset_now     = reset_req && !byte_valid;
	assign reset_pending = pending_ff;
	assign engine_busy   = (state_ff == crc_pkg::ENG_FOLD);

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_ff   <= crc_pkg::ENG_IDLE;
			crc_ff     <= crc_pkg::RESET_INIT;
			pending_ff <= 1'b0;
		end
		else
		begin
			pending_ff <= reset_req && byte_valid;
			if (reset_now)
			begin
				// Drops any byte in the fold stage
				// Whole init word, a narrow width only looks at its low bits
				crc_ff   <= init_ff;
				state_ff <= crc_pkg::ENG_IDLE;
			end
			else
			begin
				if (state_ff == crc_pkg::ENG_FOLD)
					crc_ff <= fold_byte(crc_ff, byte_ff, poly_ff, crc_poly_size);
				state_ff <= take ? crc_pkg::ENG_FOLD : crc_pkg::ENG_IDLE;
			end
		end
	end

	// Fold stage operand
	always_ff @(posedge HCLK)
	begin
		if (take)
			byte_ff <= byte_data;
	end

	//////////////////////////////
	// Configuration registers
	//////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_ff <= crc_pkg::RESET_INIT;
			poly_ff <= crc_pkg::RESET_POLY;
			idr_ff  <= 8'h00;
		end
		else
		begin
			if (crc_init_en)
				init_ff <= bus_wr;
			if (crc_poly_en)
				poly_ff <= bus_wr;
			if (crc_idr_en)
				idr_ff <= bus_wr[7:0];
		end
	end

	assign crc_init_out = init_ff;
	assign crc_poly_out = poly_ff;
	assign crc_idr_out  = idr_ff;

	// Output reversal spans the selected width only
	always_comb
	begin
		case (crc_poly_size)
			crc_pkg::POLY_16: rev_shift = 5'd16;
			crc_pkg::POLY_8:  rev_shift = 5'd24;
			crc_pkg::POLY_7:  rev_shift = 5'd25;
			default:          rev_shift = 5'd0;
		endcase
		crc_masked = crc_ff & width_mask(crc_poly_size);
		for (int i = 0; i < 32; i++)
			crc_mirror[i] = crc_masked[31 - i];
		crc_out = rev_out_type ? (crc_mirror >> rev_shift) : crc_masked;
	end

endmodule

/* source/crc_data_buffer.sv */
//////////////////////////////
// One-word holding stage ahead of the CRC engine
// A new word is accepted only when the stage is empty
//////////////////////////////
`timescale 1ns/1ps

module crc_data_buffer
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic                buffer_write_en,
	input  crc_pkg::crc_word_t  bus_wr,
	input  crc_pkg::bus_size_t  bus_size,
	input  crc_pkg::rev_in_t    rev_in_type,
	input  logic                engine_busy,
	input  logic                byte_ready,
	output logic                buffer_full,
	output logic                read_wait,
	output logic                byte_valid,
	output crc_pkg::crc_byte_t  byte_data
);

	crc_pkg::crc_word_t data_ff;
	logic [2:0]         count_ff;
	logic [2:0]         count_in;
	crc_pkg::rev_in_t   rev_eff;
	logic               holding;

	// Mirror each bit within its byte, halfword or the whole word
	function automatic crc_pkg::crc_word_t reverse_in(input crc_pkg::crc_word_t w,
	                                                  input crc_pkg::rev_in_t kind);
		crc_pkg::crc_word_t r;
		r = w;
		for (int i = 0; i < 32; i++)
		begin
			case (kind)
				crc_pkg::REV_BYTE: r[i] = w[(i & ~7) + 7 - (i & 7)];
				crc_pkg::REV_HALF: r[i] = w[(i & ~15) + 15 - (i & 15)];
				crc_pkg::REV_WORD: r[i] = w[31 - i];
				default:           r[i] = w[i];
			endcase
		end
		return r;
	endfunction

	// Reversal never reaches past the transferred size
	always_comb
	begin
		rev_eff  = rev_in_type;
		count_in = 3'd4;
		case (bus_size)
			crc_pkg::SIZE_BYTE:
			begin
				count_in = 3'd1;
				if (rev_in_type != crc_pkg::REV_NONE)
					rev_eff = crc_pkg::REV_BYTE;
			end
			crc_pkg::SIZE_HALF:
			begin
				count_in = 3'd2;
				if (rev_in_type == crc_pkg::REV_WORD)
					rev_eff = crc_pkg::REV_HALF;
			end
			default:
				count_in = 3'd4;
		endcase
	end

	// Bytes left to hand over
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count_ff <= 3'd0;
		else if (buffer_write_en)
			count_ff <= count_in;
		else if (byte_valid && byte_ready)
			count_ff <= count_ff - 3'd1;
	end

	// Least significant byte always sits at the bottom
	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
			data_ff <= reverse_in(bus_wr, rev_eff);
		else if (byte_valid && byte_ready)
			data_ff <= data_ff >> 8;
	end

	assign holding     = (count_ff != 3'd0);
	assign byte_valid  = holding;
	assign byte_data   = data_ff[7:0];
	assign buffer_full = holding;
	// DR is stale until both stages have drained
	assign read_wait   = holding || engine_busy;

endmodule

/* host_interface/host_interface.sv */
//////////////////////////////
// AHB-Lite slave front end of the CRC unit
// Only NONSEQ transfers act, BUSY and SEQ count as IDLE
// HRESP is always OKAY
// Narrow writes carry data on the low lanes of HWDATA
//////////////////////////////
`timescale 1ns/1ps

module host_interface
(
	input  logic                  HCLK,
	input  logic                  HRESETn,
	input  logic                  HSElx,
	input  logic [31:0]           HADDR,
	input  logic [1:0]            HTRANS,
	input  logic                  HWRITE,
	input  logic [2:0]            HSIZE,
	input  crc_pkg::crc_word_t    HWDATA,
	input  logic                  HREADY,
	output crc_pkg::crc_word_t    HRDATA,
	output logic                  HREADYOUT,
	output logic                  HRESP,
	output crc_pkg::crc_word_t    bus_wr,
	output crc_pkg::bus_size_t    bus_size,
	output logic                  buffer_write_en,
	output logic                  crc_init_en,
	output logic                  crc_idr_en,
	output logic                  crc_poly_en,
	output logic                  reset_chain,
	output crc_pkg::poly_size_t   crc_poly_size,
	output crc_pkg::rev_in_t      rev_in_type,
	output logic                  rev_out_type,
	input  crc_pkg::crc_word_t    crc_out,
	input  crc_pkg::crc_word_t    crc_init_out,
	input  crc_pkg::crc_word_t    crc_poly_out,
	input  crc_pkg::crc_byte_t    crc_idr_out,
	input  logic                  buffer_full,
	input  logic                  reset_pending,
	input  logic                  read_wait
);

	// HTRANS code that starts a transfer
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	// Only response ever given
	localparam logic HRESP_OKAY = 1'b0;

	// Address phase captured for the data phase
	crc_pkg::reg_addr_t haddr_pp;
	crc_pkg::bus_size_t hsize_pp;
	logic [1:0]         htrans_pp;
	logic               hwrite_pp;
	logic               hselx_pp;

	// CR bits 7:3
	logic [4:0] cr_ff;

	logic sample_bus;
	logic xfer_act;
	logic write_act;
	logic read_act;
	logic dr_sel;
	logic idr_sel;
	logic cr_sel;
	logic init_sel;
	logic poly_sel;
	logic dr_write;
	logic dr_read;
	logic init_write;
	logic cr_write;
	crc_pkg::crc_word_t cr_rd;

	//////////////////////////////
	// Address phase pipeline
	//////////////////////////////

	// A new address phase is taken only when the bus moves on
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			hselx_pp <= HSElx;
		end
	end

	// Payload of the address phase
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= HSIZE[1:0];
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
		end
	end

	//////////////////////////////
	// Data phase decode
	//////////////////////////////

	assign xfer_act  = hselx_pp && (htrans_pp == HTRANS_NONSEQ);
	assign write_act = xfer_act && hwrite_pp;
	assign read_act  = xfer_act && !hwrite_pp;

	assign dr_sel   = (haddr_pp == crc_pkg::CRC_DR_ADDR);
	assign idr_sel  = (haddr_pp == crc_pkg::CRC_IDR_ADDR);
	assign cr_sel   = (haddr_pp == crc_pkg::CRC_CR_ADDR);
	assign init_sel = (haddr_pp == crc_pkg::CRC_INIT_ADDR);
	assign poly_sel = (haddr_pp == crc_pkg::CRC_POL_ADDR);

	assign dr_write   = dr_sel && write_act;
	assign dr_read    = dr_sel && read_act;
	assign init_write = init_sel && write_act;
	assign cr_write   = cr_sel && write_act;

	// Wait states for the three stall cases
	assign HREADYOUT = !((dr_write && buffer_full) ||
	                     (dr_read && read_wait) ||
	                     (init_write && reset_pending));

	assign HRESP = HRESP_OKAY;

	// Writes act only on the completing cycle of the data phase
	assign buffer_write_en = dr_write && HREADYOUT;
	assign crc_init_en     = init_write && HREADYOUT;
	assign crc_idr_en      = idr_sel && write_act && HREADYOUT;
	assign crc_poly_en     = poly_sel && write_act && HREADYOUT;

	// Write data is already in its data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	//////////////////////////////
	// Control register
	//////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			cr_ff <= crc_pkg::RESET_CR[7:3];
		end
		else if (cr_write && HREADYOUT)
		begin
			cr_ff <= HWDATA[7:3];
		end
	end

	// Bit 0 is a self-clearing reset request
	assign reset_chain   = cr_write && HREADYOUT && HWDATA[0];
	assign crc_poly_size = cr_ff[1:0];
	assign rev_in_type   = cr_ff[3:2];
	assign rev_out_type  = cr_ff[4];

	// Readback mux
	assign cr_rd  = {24'h0, cr_ff, 3'h0};
	assign HRDATA = ({32{dr_sel}}   & crc_out) |
	                ({32{init_sel}} & crc_init_out) |
	                ({32{idr_sel}}  & {24'h0, crc_idr_out}) |
	                ({32{poly_sel}} & crc_poly_out) |
	                ({32{cr_sel}}   & cr_rd);

endmodule

/* common/crc_pkg.sv */
//////////////////////////////
// Register map and encodings of the CRC unit
// Widths are fixed by the 32-bit AHB-Lite bus
// HSIZE codes above word are not supported
//////////////////////////////
package crc_pkg;

	// Data word, register value or CRC value
	typedef logic [31:0] crc_word_t;
	// One byte handed to the engine
	typedef logic [7:0] crc_byte_t;
	// Register index from HADDR[4:2]
	typedef logic [2:0] reg_addr_t;
	// Transfer size from HSIZE[1:0]
	typedef logic [1:0] bus_size_t;
	// CR polynomial size field
	typedef logic [1:0] poly_size_t;
	// CR input reversal field
	typedef logic [1:0] rev_in_t;

	// Register index map
	localparam reg_addr_t CRC_DR_ADDR   = 3'd0;
	localparam reg_addr_t CRC_IDR_ADDR  = 3'd1;
	localparam reg_addr_t CRC_CR_ADDR   = 3'd2;
	localparam reg_addr_t CRC_INIT_ADDR = 3'd4;
	localparam reg_addr_t CRC_POL_ADDR  = 3'd5;

	// Transfer sizes
	localparam bus_size_t SIZE_BYTE = 2'd0;
	localparam bus_size_t SIZE_HALF = 2'd1;

	// Polynomial sizes
	localparam poly_size_t POLY_32 = 2'd0;
	localparam poly_size_t POLY_16 = 2'd1;
	localparam poly_size_t POLY_8  = 2'd2;
	localparam poly_size_t POLY_7  = 2'd3;

	// Input reversal kinds
	localparam rev_in_t REV_NONE = 2'd0;
	localparam rev_in_t REV_BYTE = 2'd1;
	localparam rev_in_t REV_HALF = 2'd2;
	localparam rev_in_t REV_WORD = 2'd3;

	// Reset values
	localparam crc_word_t RESET_INIT = 32'hFFFF_FFFF;
	localparam crc_word_t RESET_POLY = 32'h04C1_1DB7;
	localparam crc_word_t RESET_CR   = 32'h0000_0000;

	// Engine FSM
	typedef enum logic {ENG_IDLE, ENG_FOLD} crc_state_e;

endpackage
